// File: iosystem.f
src/io_map_pkg.sv
src/io_types_pkg.sv
src/io_regs.sv
src/input_conditioner.sv
src/seven_seg_scan.sv
src/ms_timer.sv
src/uart_tx.sv
src/iosystem.sv
sim/iosystem_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the I/O block testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f iosystem.f --top-module iosystem_tb \
    -Mdir obj_dir -o iosystem_sim

./obj_dir/iosystem_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "^RESULT: PASS$" sim.log; then
    echo "Simulation passed"
    exit 0
else
    echo "Simulation failed"
    exit 1
fi

// File: sim/iosystem_tb.sv
//////////////////////////////////////////////////////////////////////
// Testbench for the memory-mapped I/O block
// Drives the bus, switches and buttons, watches display and serial line
// Concurrent and immediate assertions compare against testbench models
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module iosystem_tb;

    import io_map_pkg::*;
    import io_types_pkg::*;

    localparam int          MS_CLKS    = 20;
    localparam int          BIT_CLKS   = 8;
    localparam int          DEB_CYCLES = 5;
    localparam int          SCAN_CLKS  = 4;
    localparam logic [31:0] SEED       = 32'he143_5bbe;

    logic        clk;
    logic        rst;
    bus_req_t    bus_i;
    logic [15:0] sw_i;
    buttons_t    btn_i;
    logic [31:0] read_data_o;
    logic        read_valid_o;
    logic [15:0] led_o;
    seg_out_t    seg_o;
    logic        uart_txd_o;

    // Models and check enables
    int          value_errs = 0;
    int          other_errs = 0;
    logic        chk_rd;
    logic [31:0] exp_lo;
    logic [31:0] exp_hi;
    logic [15:0] led_model;
    logic [15:0] seg_data_model;
    seg_ctrl_t   seg_ctrl_model;
    logic        seg_chk;
    logic [3:0]  seen_digits;
    logic [1:0]  lit_digit;
    logic [6:0]  exp_segs;
    logic        exp_dp;

    iosystem #(
        .CLKS_PER_MS     (MS_CLKS),
        .CLKS_PER_BIT    (BIT_CLKS),
        .DEBOUNCE_CYCLES (DEB_CYCLES),
        .SCAN_CYCLES     (SCAN_CLKS)
    ) UUT (
        .clk          (clk),
        .rst          (rst),
        .bus_i        (bus_i),
        .sw_i         (sw_i),
        .btn_i        (btn_i),
        .read_data_o  (read_data_o),
        .read_valid_o (read_valid_o),
        .led_o        (led_o),
        .seg_o        (seg_o),
        .uart_txd_o   (uart_txd_o)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    //////////////////////////////////////////////////////////////////
    // Reference tables and reporting
    //////////////////////////////////////////////////////////////////

    // Segments active high, gfedcba
    function automatic logic [6:0] hex_segs(input logic [3:0] n);
        case (n)
            4'h0: hex_segs = 7'b0111111;
            4'h1: hex_segs = 7'b0000110;
            4'h2: hex_segs = 7'b1011011;
            4'h3: hex_segs = 7'b1001111;
            4'h4: hex_segs = 7'b1100110;
            4'h5: hex_segs = 7'b1101101;
            4'h6: hex_segs = 7'b1111101;
            4'h7: hex_segs = 7'b0000111;
            4'h8: hex_segs = 7'b1111111;
            4'h9: hex_segs = 7'b1101111;
            4'hA: hex_segs = 7'b1110111;
            4'hB: hex_segs = 7'b1111100;
            4'hC: hex_segs = 7'b0111001;
            4'hD: hex_segs = 7'b1011110;
            4'hE: hex_segs = 7'b1111001;
            default: hex_segs = 7'b1110001;
        endcase
    endfunction

    function automatic logic [31:0] reg_addr(input io_reg_e r);
        return IO_BASE_ADDR + {26'h0, r, 2'b00};
    endfunction

    task automatic value_error(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        value_errs++;
        $display("ERR t=%0t %s got 0x%0h expected 0x%0h", $time, name, got, exp);
    endtask

    //////////////////////////////////////////////////////////////////
    // Monitors and concurrent checks, sampled on the falling edge
    //////////////////////////////////////////////////////////////////

    // Index of the lit digit, lowest low anode
    always_comb begin
        lit_digit = 2'd0;
        for (int d = 3; d >= 0; d--) begin
            if (!seg_o.anode[d]) lit_digit = 2'(d);
        end
    end

    assign exp_segs = ~hex_segs(seg_data_model[lit_digit*4 +: 4]);
    assign exp_dp   = ~seg_ctrl_model.digit_pt[lit_digit];

    // Digits seen lit during one monitored scan
    always @(negedge clk) begin
        if (!seg_chk) seen_digits <= 4'h0;
        else          seen_digits <= seen_digits | ~seg_o.anode;
    end

    a_read: assert property (@(negedge clk) disable iff (rst)
        (chk_rd && read_valid_o) |-> (read_data_o >= exp_lo && read_data_o <= exp_hi))
        else value_error("read_data_o", read_data_o, exp_lo);

    a_led: assert property (@(negedge clk) disable iff (rst) led_o == led_model)
        else value_error("led_o", 32'(led_o), 32'(led_model));

    a_seg_en: assert property (@(negedge clk) disable iff (rst)
        seg_chk |-> ((~seg_o.anode & ~seg_ctrl_model.digit_en) == 4'h0
                     && $countones(~seg_o.anode) <= 1))
        else begin
            other_errs++;
            $display("Display drove anodes %b with enables %b", seg_o.anode,
                     seg_ctrl_model.digit_en);
        end

    a_seg_pat: assert property (@(negedge clk) disable iff (rst)
        (seg_chk && seg_o.anode != 4'hF) |-> seg_o.segs == exp_segs)
        else value_error("seg_o.segs", 32'(seg_o.segs), 32'(exp_segs));

    a_seg_dp: assert property (@(negedge clk) disable iff (rst)
        (seg_chk && seg_o.anode != 4'hF) |-> seg_o.dp == exp_dp)
        else value_error("seg_o.dp", 32'(seg_o.dp), 32'(exp_dp));

    //////////////////////////////////////////////////////////////////
    // Bus and peripheral tasks
    //////////////////////////////////////////////////////////////////

    // Hit means the address is in the window and a response is due
    task automatic write_word(input logic [31:0] addr, input logic [31:0] data,
                              input logic hit);
        int waited;
        waited = 0;
        @(posedge clk);
        #2;
        bus_i.read  = 1'b0;
        bus_i.write = 1'b1;
        bus_i.addr  = addr;
        bus_i.wdata = data;
        @(posedge clk);
        #2;
        bus_i = '0;
        if (hit) begin
            while (!read_valid_o && waited < 10) begin
                @(posedge clk);
                #2;
                waited++;
            end
            if (!read_valid_o) begin
                other_errs++;
                $display("Write to 0x%0h got no response", addr);
            end
        end else begin
            repeat (3) begin
                assert (!read_valid_o) else begin
                    other_errs++;
                    $display("Response raised for address 0x%0h outside the window", addr);
                end
                @(posedge clk);
                #2;
            end
        end
    endtask

    // Check off leaves the returned word unchecked
    task automatic read_word(input logic [31:0] addr, input logic check,
                             input logic [31:0] lo, input logic [31:0] hi,
                             output logic [31:0] data);
        int waited;
        waited = 0;
        @(posedge clk);
        #2;
        exp_lo      = lo;
        exp_hi      = hi;
        chk_rd      = check;
        bus_i.read  = 1'b1;
        bus_i.write = 1'b0;
        bus_i.addr  = addr;
        bus_i.wdata = '0;
        @(posedge clk);
        #2;
        bus_i = '0;
        while (!read_valid_o && waited < 10) begin
            @(posedge clk);
            #2;
            waited++;
        end
        if (!read_valid_o) begin
            other_errs++;
            $display("Read from 0x%0h got no response", addr);
        end
        data = read_data_o;
        @(negedge clk);
        #2;
        chk_rd = 1'b0;
    endtask

    // Debounce latency varies, poll until the word settles
    task automatic wait_buttons(input logic [4:0] target);
        logic [31:0] word;
        int          polls;
        polls = 0;
        read_word(reg_addr(REG_BUTTON), 1'b0, '0, '0, word);
        while (word != 32'(target) && polls < 30) begin
            read_word(reg_addr(REG_BUTTON), 1'b0, '0, '0, word);
            polls++;
        end
        assert (word == 32'(target)) else value_error("read_data_o", word, 32'(target));
    endtask

    // Two full scans whatever the starting digit
    task automatic scan_display();
        @(negedge clk);
        #2;
        seg_chk = 1'b1;
        repeat (8 * SCAN_CLKS) @(negedge clk);
        #2;
        assert (seen_digits == seg_ctrl_model.digit_en) else begin
            other_errs++;
            $display("Scan lit digits %b but enables are %b", seen_digits,
                     seg_ctrl_model.digit_en);
        end
        seg_chk = 1'b0;
    endtask

    task automatic wait_tx_idle();
        logic [31:0] status;
        int          polls;
        polls = 0;
        read_word(reg_addr(REG_TX), 1'b0, '0, '0, status);
        while (status[0] && polls < 100) begin
            read_word(reg_addr(REG_TX), 1'b0, '0, '0, status);
            polls++;
        end
        if (status[0]) begin
            other_errs++;
            $display("Transmitter stayed busy");
        end
    endtask

    // Start edge, then mid-bit samples one bit time apart
    task automatic capture_uart(output logic [7:0] data, output logic start_bit,
                                output logic stop_bit);
        int waited;
        waited    = 0;
        data      = 8'h00;
        start_bit = 1'b1;
        stop_bit  = 1'b0;
        @(negedge clk);
        while (uart_txd_o && waited < 200) begin
            @(negedge clk);
            waited++;
        end
        if (uart_txd_o) begin
            other_errs++;
            $display("No start bit seen on the serial line");
        end else begin
            repeat (BIT_CLKS / 2 - 1) @(negedge clk);
            start_bit = uart_txd_o;
            for (int i = 0; i < 8; i++) begin
                repeat (BIT_CLKS) @(negedge clk);
                data[i] = uart_txd_o;
            end
            repeat (BIT_CLKS) @(negedge clk);
            stop_bit = uart_txd_o;
        end
    endtask

    task automatic check_line_idle(input int cycles);
        repeat (cycles) begin
            @(negedge clk);
            assert (uart_txd_o) else begin
                other_errs++;
                $display("Serial line left idle after a dropped send");
            end
        end
    endtask

    //////////////////////////////////////////////////////////////////
    // Stimulus
    //////////////////////////////////////////////////////////////////

    initial begin
        logic [31:0] rnd;
        logic [31:0] rd;
        logic [7:0]  tx_byte;
        logic [7:0]  got_byte;
        logic        start_bit;
        logic        stop_bit;
        int          bidx;
        int          n;
        void'($urandom(SEED));
        rst            = 1'b1;
        bus_i          = '0;
        sw_i           = '0;
        btn_i          = '0;
        chk_rd         = 1'b0;
        seg_chk        = 1'b0;
        exp_lo         = '0;
        exp_hi         = '0;
        led_model      = '0;
        seg_data_model = '0;
        seg_ctrl_model = seg_ctrl_t'(SEG_CTRL_RESET);
        repeat (3) @(posedge clk);
        #2;
        rst = 1'b0;

        // Reset state
        @(negedge clk);
        assert (uart_txd_o === 1'b1) else value_error("uart_txd_o", 32'(uart_txd_o), 1);
        assert (read_valid_o === 1'b0) else value_error("read_valid_o", 32'(read_valid_o), 0);

        // LED register, upper write bits must not read back
        repeat (4) begin
            rnd = $urandom();
            write_word(reg_addr(REG_LED), rnd, 1'b1);
            led_model = rnd[15:0];
            read_word(reg_addr(REG_LED), 1'b1, 32'(led_model), 32'(led_model), rd);
        end
        write_word(32'h0000_7E00, 32'(~led_model), 1'b0);
        read_word(reg_addr(REG_LED), 1'b1, 32'(led_model), 32'(led_model), rd);
        read_word(IO_BASE_ADDR + 32'h0C, 1'b1, '0, '0, rd);

        // Switches through the synchronizer
        repeat (4) begin
            @(posedge clk);
            #2;
            sw_i = 16'($urandom());
            repeat (3) @(posedge clk);
            read_word(reg_addr(REG_SWITCH), 1'b1, 32'(sw_i), 32'(sw_i), rd);
        end

        // Held button, release, then a short glitch
        bidx = int'($urandom_range(4, 0));
        @(posedge clk);
        #2;
        btn_i = buttons_t'(5'b00001 << bidx);
        wait_buttons(5'b00001 << bidx);
        @(posedge clk);
        #2;
        btn_i = '0;
        wait_buttons(5'b00000);
        @(posedge clk);
        #2;
        btn_i = buttons_t'(5'b00001 << ((bidx + 1) % 5));
        repeat (DEB_CYCLES - 2) @(posedge clk);
        #2;
        btn_i = '0;
        repeat (10) read_word(reg_addr(REG_BUTTON), 1'b1, '0, '0, rd);

        // Display, first pass with the reset control word
        for (int pass = 0; pass < 3; pass++) begin
            rnd = $urandom();
            write_word(reg_addr(REG_SEG_DATA), rnd, 1'b1);
            seg_data_model = rnd[15:0];
            if (pass > 0) begin
                rnd = $urandom();
                write_word(reg_addr(REG_SEG_CTRL), rnd, 1'b1);
                seg_ctrl_model = seg_ctrl_t'(rnd[7:0]);
            end
            read_word(reg_addr(REG_SEG_CTRL), 1'b1, 32'(seg_ctrl_model),
                      32'(seg_ctrl_model), rd);
            scan_display();
        end

        // Timer load and count
        repeat (3) begin
            rnd = $urandom() & 32'h7FFF_FFFF;
            n   = int'($urandom_range(6, 2));
            write_word(reg_addr(REG_TIMER), rnd, 1'b1);
            repeat (n * MS_CLKS) @(posedge clk);
            read_word(reg_addr(REG_TIMER), 1'b1, rnd + 32'(n), rnd + 32'(n) + 1, rd);
        end

        // Serial frames, second write lands while busy
        repeat (2) begin
            wait_tx_idle();
            tx_byte = 8'($urandom());
            fork
                capture_uart(got_byte, start_bit, stop_bit);
                begin
                    write_word(reg_addr(REG_TX), 32'(tx_byte), 1'b1);
                    repeat (2 * BIT_CLKS) @(posedge clk);
                    write_word(reg_addr(REG_TX), 32'(~tx_byte), 1'b1);
                    // Busy bit reads set mid-frame
                    read_word(reg_addr(REG_TX), 1'b1, 32'd1, 32'd1, rd);
                end
            join
            assert (start_bit == 1'b0) else value_error("uart start bit", 32'(start_bit), 0);
            assert (got_byte == tx_byte) else
                value_error("uart_txd_o byte", 32'(got_byte), 32'(tx_byte));
            assert (stop_bit == 1'b1) else value_error("uart stop bit", 32'(stop_bit), 1);
            check_line_idle(3 * BIT_CLKS);
            wait_tx_idle();
        end

        $display("Checks done: %0d value errors, %0d other errors", value_errs, other_errs);
        if (value_errs == 0 && other_errs == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: src/iosystem.sv
//////////////////////////////////////////////////////////////////////
// Memory-mapped I/O block for the teaching processor
// Connects the register file to the board peripherals
// Clock-derived counts are set here and handed to each peripheral
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module iosystem #(
    parameter int CLKS_PER_MS     = 100_000,
    parameter int CLKS_PER_BIT    = 868,
    parameter int DEBOUNCE_CYCLES = 1_000_000,
    parameter int SCAN_CYCLES     = 100_000
) (
    input  wire logic                          clk,
    input  wire logic                          rst,
    input  wire io_types_pkg::bus_req_t        bus_i,
    input  wire logic [15:0]                   sw_i,
    input  wire io_types_pkg::buttons_t        btn_i,
    output      logic [io_map_pkg::DATA_W-1:0] read_data_o,
    output      logic                          read_valid_o,
    output      logic [15:0]                   led_o,
    output      io_types_pkg::seg_out_t        seg_o,
    output      logic                          uart_txd_o
);

    import io_map_pkg::*;
    import io_types_pkg::*;

    // Conditioned inputs
    logic [15:0]       sw_sync;
    buttons_t          btn_deb;
    // Peripheral side of the register file
    logic [15:0]       seg_data;
    seg_ctrl_t         seg_ctrl;
    logic              tx_send;
    logic [7:0]        tx_byte;
    logic              tx_busy;
    logic              timer_load;
    logic [DATA_W-1:0] timer_value;
    logic [DATA_W-1:0] timer_count;

    io_regs u_regs (
        .clk           (clk),
        .rst           (rst),
        .bus_i         (bus_i),
        .sw_i          (sw_sync),
        .btn_i         (btn_deb),
        .timer_count_i (timer_count),
        .tx_busy_i     (tx_busy),
        .read_data_o   (read_data_o),
        .read_valid_o  (read_valid_o),
        .led_o         (led_o),
        .seg_data_o    (seg_data),
        .seg_ctrl_o    (seg_ctrl),
        .tx_send_o     (tx_send),
        .tx_byte_o     (tx_byte),
        .timer_load_o  (timer_load),
        .timer_value_o (timer_value)
    );

    input_conditioner #(.DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)) u_inputs (
        .clk   (clk),
        .rst   (rst),
        .sw_i  (sw_i),
        .btn_i (btn_i),
        .sw_o  (sw_sync),
        .btn_o (btn_deb)
    );

    seven_seg_scan #(.SCAN_CYCLES(SCAN_CYCLES)) u_seg (
        .clk    (clk),
        .rst    (rst),
        .data_i (seg_data),
        .ctrl_i (seg_ctrl),
        .seg_o  (seg_o)
    );

    ms_timer #(.CLKS_PER_MS(CLKS_PER_MS)) u_timer (
        .clk          (clk),
        .rst          (rst),
        .load_i       (timer_load),
        .load_value_i (timer_value),
        .count_o      (timer_count)
    );

    uart_tx #(.CLKS_PER_BIT(CLKS_PER_BIT)) u_tx (
        .clk    (clk),
        .rst    (rst),
        .send_i (tx_send),
        .byte_i (tx_byte),
        .busy_o (tx_busy),
        .txd_o  (uart_txd_o)
    );

endmodule

`default_nettype wire

// File: src/uart_tx.sv
//////////////////////////////////////////////////////////////////////
// UART transmitter, 8 data bits LSB first, 1 stop bit, no parity
// Send is taken only in idle, busy rises on the following cycle
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module uart_tx #(
    parameter int CLKS_PER_BIT = 868
) (
    input  wire logic       clk,
    input  wire logic       rst,
    input  wire logic       send_i,
    input  wire logic [7:0] byte_i,
    output      logic       busy_o,
    output      logic       txd_o
);

    localparam int BIT_W = $clog2(CLKS_PER_BIT + 1);

    typedef enum logic [1:0] {
        TX_IDLE,
        TX_START,
        TX_DATA,
        TX_STOP
    } tx_state_e;

    tx_state_e        state;
    logic [BIT_W-1:0] bit_timer;
    logic [2:0]       bit_idx;
    logic [7:0]       shift_reg;
    logic             bit_done;

    assign bit_done = (bit_timer == BIT_W'(CLKS_PER_BIT - 1));

    // Control FSM and bit timing
    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= TX_IDLE;
            bit_timer <= '0;
            bit_idx   <= '0;
        end else begin
            bit_timer <= (state == TX_IDLE || bit_done) ? '0 : bit_timer + 1'b1;
            case (state)
                TX_IDLE: begin
                    // Send while busy never reaches here
                    if (send_i) begin
                        state <= TX_START;
                    end
                end
                TX_START: begin
                    if (bit_done) begin
                        state   <= TX_DATA;
                        bit_idx <= '0;
                    end
                end
                TX_DATA: begin
                    if (bit_done) begin
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) begin
                            state <= TX_STOP;
                        end
                    end
                end
                default: begin
                    if (bit_done) begin
                        state <= TX_IDLE;
                    end
                end
            endcase
        end
    end

    // Data byte, shifted out LSB first
    always_ff @(posedge clk) begin
        if (state == TX_IDLE && send_i) begin
            shift_reg <= byte_i;
        end else if (state == TX_DATA && bit_done) begin
            shift_reg <= {1'b0, shift_reg[7:1]};
        end
    end

    assign busy_o = (state != TX_IDLE);

    // Line idles high
    always_comb begin
        case (state)
            TX_START: txd_o = 1'b0;
            TX_DATA:  txd_o = shift_reg[0];
            default:  txd_o = 1'b1;
        endcase
    end

endmodule

`default_nettype wire

// File: src/ms_timer.sv
//////////////////////////////////////////////////////////////////////
// Millisecond counter, advances once every CLKS_PER_MS clocks
// A software load sets the count and restarts the prescaler
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module ms_timer #(
    parameter int CLKS_PER_MS = 100_000
) (
    input  wire logic                          clk,
    input  wire logic                          rst,
    input  wire logic                          load_i,
    input  wire logic [io_map_pkg::DATA_W-1:0] load_value_i,
    output      logic [io_map_pkg::DATA_W-1:0] count_o
);

    localparam int PRE_W = $clog2(CLKS_PER_MS + 1);

    logic [PRE_W-1:0] prescale;

    always_ff @(posedge clk) begin
        if (rst) begin
            prescale <= '0;
            count_o  <= '0;
        end else if (load_i) begin
            // Load wins over the tick
            prescale <= '0;
            count_o  <= load_value_i;
        end else if (prescale == PRE_W'(CLKS_PER_MS - 1)) begin
            prescale <= '0;
            count_o  <= count_o + 1'b1;
        end else begin
            prescale <= prescale + 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: src/seven_seg_scan.sv
//////////////////////////////////////////////////////////////////////
// Four digit multiplexed seven-segment driver with hex decode
// Each digit holds the pins for SCAN_CYCLES clocks, digit 0 first
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module seven_seg_scan #(
    parameter int SCAN_CYCLES = 100_000
) (
    input  wire logic                    clk,
    input  wire logic                    rst,
    input  wire logic [15:0]             data_i,
    input  wire io_types_pkg::seg_ctrl_t ctrl_i,
    output      io_types_pkg::seg_out_t  seg_o
);

    localparam int PRE_W = $clog2(SCAN_CYCLES + 1);

    logic [PRE_W-1:0] prescale;
    logic [1:0]       digit;
    logic [3:0]       nibble;
    logic [6:0]       pattern;

    // Dwell counter and digit index
    always_ff @(posedge clk) begin
        if (rst) begin
            prescale <= '0;
            digit    <= '0;
        end else if (prescale == PRE_W'(SCAN_CYCLES - 1)) begin
            prescale <= '0;
            digit    <= digit + 1'b1;
        end else begin
            prescale <= prescale + 1'b1;
        end
    end

    assign nibble = data_i[digit*4 +: 4];

    // Hex to segments, active low, gfedcba
    always_comb begin
        case (nibble)
            4'h0: pattern = ~7'h3F;
            4'h1: pattern = ~7'h06;
            4'h2: pattern = ~7'h5B;
            4'h3: pattern = ~7'h4F;
            4'h4: pattern = ~7'h66;
            4'h5: pattern = ~7'h6D;
            4'h6: pattern = ~7'h7D;
            4'h7: pattern = ~7'h07;
            4'h8: pattern = ~7'h7F;
            4'h9: pattern = ~7'h6F;
            4'hA: pattern = ~7'h77;
            4'hB: pattern = ~7'h7C;
            4'hC: pattern = ~7'h39;
            4'hD: pattern = ~7'h5E;
            4'hE: pattern = ~7'h79;
            default: pattern = ~7'h71;
        endcase
    end

    // Disabled digit keeps its anode high
    assign seg_o.anode = ~((4'b0001 << digit) & ctrl_i.digit_en);
    assign seg_o.segs  = pattern;
    assign seg_o.dp    = ~ctrl_i.digit_pt[digit];

endmodule

`default_nettype wire

// File: src/input_conditioner.sv
//////////////////////////////////////////////////////////////////////
// Synchronizers for switches and buttons, debounce for buttons
// A button output moves only after a stable synchronized level
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module input_conditioner #(
    parameter int DEBOUNCE_CYCLES = 1_000_000
) (
    input  wire logic                   clk,
    input  wire logic                   rst,
    input  wire logic [15:0]            sw_i,
    input  wire io_types_pkg::buttons_t btn_i,
    output      logic [15:0]            sw_o,
    output      io_types_pkg::buttons_t btn_o
);

    import io_types_pkg::*;

    localparam int NUM_BTN = $bits(buttons_t);
    localparam int CNT_W   = $clog2(DEBOUNCE_CYCLES + 1);

    logic [15:0]        sw_meta;
    logic [NUM_BTN-1:0] btn_meta;
    logic [NUM_BTN-1:0] btn_sync;
    logic [NUM_BTN-1:0] btn_deb;
    logic [CNT_W-1:0]   stable_cnt [NUM_BTN];

    // Two flops on every input
    always_ff @(posedge clk) begin
        if (rst) begin
            sw_meta  <= '0;
            sw_o     <= '0;
            btn_meta <= '0;
            btn_sync <= '0;
        end else begin
            sw_meta  <= sw_i;
            sw_o     <= sw_meta;
            btn_meta <= btn_i;
            btn_sync <= btn_meta;
        end
    end

    // Per button counter, restarts whenever the level matches again
    always_ff @(posedge clk) begin
        if (rst) begin
            btn_deb <= '0;
            for (int i = 0; i < NUM_BTN; i++) begin
                stable_cnt[i] <= '0;
            end
        end else begin
            for (int i = 0; i < NUM_BTN; i++) begin
                if (btn_sync[i] == btn_deb[i]) begin
                    stable_cnt[i] <= '0;
                end else if (stable_cnt[i] == CNT_W'(DEBOUNCE_CYCLES - 1)) begin
                    // Held long enough, take the new level
                    btn_deb[i]    <= btn_sync[i];
                    stable_cnt[i] <= '0;
                end else begin
                    stable_cnt[i] <= stable_cnt[i] + 1'b1;
                end
            end
        end
    end

    assign btn_o = buttons_t'(btn_deb);

endmodule

`default_nettype wire

// File: src/io_regs.sv
//////////////////////////////////////////////////////////////////////
// Bus decode and register file of the I/O block
// Writes act at the request edge, reads return one cycle later
// Peripheral strobes are one-cycle pulses taken from the bus write
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module io_regs (
    input  wire logic                              clk,
    input  wire logic                              rst,
    input  wire io_types_pkg::bus_req_t            bus_i,
    input  wire logic [15:0]                       sw_i,
    input  wire io_types_pkg::buttons_t            btn_i,
    input  wire logic [io_map_pkg::DATA_W-1:0]     timer_count_i,
    input  wire logic                              tx_busy_i,
    output      logic [io_map_pkg::DATA_W-1:0]     read_data_o,
    output      logic                              read_valid_o,
    output      logic [15:0]                       led_o,
    output      logic [15:0]                       seg_data_o,
    output      io_types_pkg::seg_ctrl_t           seg_ctrl_o,
    output      logic                              tx_send_o,
    output      logic [7:0]                        tx_byte_o,
    output      logic                              timer_load_o,
    output      logic [io_map_pkg::DATA_W-1:0]     timer_value_o
);

    import io_map_pkg::*;

    logic              in_window;
    logic              wr_en;
    io_reg_e           reg_idx;
    logic [DATA_W-1:0] rd_next;

    //////////////////////////////////////////////////////////////////
    // Address decode
    //////////////////////////////////////////////////////////////////

    // Upper address bits select the window
    assign in_window = (bus_i.addr[DATA_W-1:IO_ADDR_BITS] ==
                        IO_BASE_ADDR[DATA_W-1:IO_ADDR_BITS]);
    assign reg_idx   = io_reg_e'(bus_i.addr[5:2]);
    assign wr_en     = in_window && bus_i.write;

    // Peripheral strobes, payload straight from the write data
    assign tx_send_o     = wr_en && (reg_idx == REG_TX);
    assign timer_load_o  = wr_en && (reg_idx == REG_TIMER);
    assign tx_byte_o     = bus_i.wdata[7:0];
    assign timer_value_o = bus_i.wdata;

    //////////////////////////////////////////////////////////////////
    // Writable registers
    //////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            led_o      <= '0;
            seg_data_o <= '0;
            seg_ctrl_o <= SEG_CTRL_RESET;
        end else if (wr_en) begin
            case (reg_idx)
                REG_LED:      led_o      <= bus_i.wdata[15:0];
                REG_SEG_DATA: seg_data_o <= bus_i.wdata[15:0];
                REG_SEG_CTRL: seg_ctrl_o <= bus_i.wdata[7:0];
                default: ;
            endcase
        end
    end

    //////////////////////////////////////////////////////////////////
    // Read path
    //////////////////////////////////////////////////////////////////

    // Zero extended, unmapped words read 0
    always_comb begin
        rd_next = '0;
        case (reg_idx)
            REG_LED:      rd_next = DATA_W'(led_o);
            REG_SWITCH:   rd_next = DATA_W'(sw_i);
            REG_TX:       rd_next = DATA_W'(tx_busy_i);
            REG_SEG_DATA: rd_next = DATA_W'(seg_data_o);
            REG_SEG_CTRL: rd_next = DATA_W'(seg_ctrl_o);
            REG_BUTTON:   rd_next = DATA_W'(btn_i);
            REG_TIMER:    rd_next = timer_count_i;
            default:      rd_next = '0;
        endcase
    end

    // Valid for any access that hit the window
    always_ff @(posedge clk) begin
        if (rst) begin
            read_valid_o <= 1'b0;
        end else begin
            read_valid_o <= in_window && (bus_i.read || bus_i.write);
        end
    end

    // Data word itself
    always_ff @(posedge clk) begin
        read_data_o <= rd_next;
    end

endmodule

`default_nettype wire

// File: src/io_types_pkg.sv
//////////////////////////////////////////////////////////////////////
// Packed struct types shared by the I/O block and its peripherals
// Bus request, button group, display control and display pins
//////////////////////////////////////////////////////////////////////
`default_nettype none

package io_types_pkg;

    // Memory stage request, read and write strobes plus address and data
    typedef struct packed {
        logic                             read;
        logic                             write;
        logic [io_map_pkg::DATA_W-1:0]    addr;
        logic [io_map_pkg::DATA_W-1:0]    wdata;
    } bus_req_t;

    // Field order is also the read word order, bit 4 down to bit 0
    typedef struct packed {
        logic up;
        logic right;
        logic down;
        logic left;
        logic center;
    } buttons_t;

    // Upper nibble digit points, lower nibble digit enables
    typedef struct packed {
        logic [3:0] digit_pt;
        logic [3:0] digit_en;
    } seg_ctrl_t;

    // Display pins, all active low
    typedef struct packed {
        logic [3:0] anode;
        logic [6:0] segs;      // a in bit 0 through g in bit 6
        logic       dp;
    } seg_out_t;

endpackage

`default_nettype wire

// File: src/io_map_pkg.sv
//////////////////////////////////////////////////////////////////////
// Address map of the I/O window seen by the processor memory stage
// Register word indices come from address bits 5:2
//////////////////////////////////////////////////////////////////////
`default_nettype none

package io_map_pkg;

    //////////////////////////////////////////////////////////////////
    // Window placement
    //////////////////////////////////////////////////////////////////

    // Bus data width
    localparam int DATA_W = 32;

    // Base of the 256 byte window
    localparam logic [DATA_W-1:0] IO_BASE_ADDR = 32'h0000_7F00;

    // Low address bits inside the window, upper bits must match base
    localparam int IO_ADDR_BITS = 8;

    //////////////////////////////////////////////////////////////////
    // Register word indices
    //////////////////////////////////////////////////////////////////

    typedef enum logic [3:0] {
        REG_LED      = 4'd0,   // byte offset 0x00
        REG_SWITCH   = 4'd1,   // 0x04, read only
        REG_TX       = 4'd2,   // 0x08, write byte / read busy
        REG_SEG_DATA = 4'd6,   // 0x18
        REG_SEG_CTRL = 4'd7,   // 0x1C
        REG_BUTTON   = 4'd9,   // 0x24, read only
        REG_TIMER    = 4'd12   // 0x30
    } io_reg_e;

    // Display control after reset, all digits on, no points
    localparam logic [7:0] SEG_CTRL_RESET = 8'h0F;

endpackage

`default_nettype wire
